// ==== rtl/mips_pkg.sv ====
package mips_pkg;

    // first fetch address after reset
    localparam logic [31:0] reset_vector = 32'hBFC0_0000;

    // memory depths in 32-bit words
    localparam int iram_words = 4096;
    localparam int dram_words = 1024;

    // primary opcodes, instr[31:26]
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_j       = 6'h02;
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_bne     = 6'h05;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_lb      = 6'h20;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_lbu     = 6'h24;
    localparam logic [5:0] op_sb      = 6'h28;
    localparam logic [5:0] op_sh      = 6'h29;
    localparam logic [5:0] op_sw      = 6'h2B;

    // function codes for op_special, instr[5:0]
    localparam logic [5:0] fn_jr   = 6'h08;
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;

    typedef enum logic [1:0] {
        alu_add,
        alu_sub,
        alu_pass_b
    } alu_op_t;

    // access width for loads and stores
    typedef enum logic [1:0] {
        size_byte,
        size_half,
        size_word
    } mem_size_t;

endpackage

// ==== rtl/mips_alu.sv ====
`timescale 1ns/1ps

module mips_alu (
    input  mips_pkg::alu_op_t op,
    input  logic [31:0]       a,
    input  logic [31:0]       b,
    output logic [31:0]       result
);

    import mips_pkg::*;

    always_comb begin
        case (op)
            alu_add: begin
                result = a + b;
            end
            alu_sub: begin
                // also the branch compare, zero means equal
                result = a - b;
            end
            default: begin
                result = b;
            end
        endcase
    end

endmodule

// ==== rtl/mips_decoder.sv ====
`timescale 1ns/1ps

module mips_decoder (
    input  logic [31:0]         instr,
    output logic [4:0]          rs,
    output logic [4:0]          rt,
    output logic [4:0]          rd,
    output logic [31:0]         imm_ext,
    output logic [25:0]         jump_index,
    output mips_pkg::alu_op_t   alu_op,
    output logic                use_imm,
    output logic                reg_write,
    output logic                write_rd,
    output logic                mem_read,
    output logic                mem_write,
    output mips_pkg::mem_size_t mem_size,
    output logic                load_unsigned,
    output logic                is_beq,
    output logic                is_bne,
    output logic                is_j,
    output logic                is_jr
);

    import mips_pkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instr[31:26];
    assign funct = instr[5:0];
    assign rs = instr[25:21];
    assign rt = instr[20:16];
    assign rd = instr[15:11];
    assign imm_ext = {{16{instr[15]}}, instr[15:0]};
    assign jump_index = instr[25:0];

    always_comb begin
        // defaults describe a no-op
        alu_op = alu_pass_b;
        use_imm = 1'b0;
        reg_write = 1'b0;
        write_rd = 1'b0;
        mem_read = 1'b0;
        mem_write = 1'b0;
        mem_size = size_word;
        load_unsigned = 1'b0;
        is_beq = 1'b0;
        is_bne = 1'b0;
        is_j = 1'b0;
        is_jr = 1'b0;

        case (opcode)
            op_special: begin
                write_rd = 1'b1;
                case (funct)
                    fn_addu: begin
                        alu_op = alu_add;
                        reg_write = 1'b1;
                    end
                    fn_subu: begin
                        alu_op = alu_sub;
                        reg_write = 1'b1;
                    end
                    fn_jr: begin
                        is_jr = 1'b1;
                    end
                    default: begin
                    end
                endcase
            end
            op_addiu: begin
                alu_op = alu_add;
                use_imm = 1'b1;
                reg_write = 1'b1;
            end
            op_lw, op_lb, op_lbu: begin
                alu_op = alu_add;
                use_imm = 1'b1;
                reg_write = 1'b1;
                mem_read = 1'b1;
                mem_size = (opcode == op_lw) ? size_word : size_byte;
                load_unsigned = (opcode == op_lbu);
            end
            op_sw, op_sh, op_sb: begin
                alu_op = alu_add;
                use_imm = 1'b1;
                mem_write = 1'b1;
                if (opcode == op_sb) begin
                    mem_size = size_byte;
                end else if (opcode == op_sh) begin
                    mem_size = size_half;
                end
            end
            op_beq: begin
                alu_op = alu_sub;
                is_beq = 1'b1;
            end
            op_bne: begin
                alu_op = alu_sub;
                is_bne = 1'b1;
            end
            op_j: begin
                is_j = 1'b1;
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== rtl/mips_regfile.sv ====
`timescale 1ns/1ps

module mips_regfile (
    input  logic        clk,
    input  logic        rst,
    input  logic [4:0]  read_reg1,
    input  logic [4:0]  read_reg2,
    output logic [31:0] read_data1,
    output logic [31:0] read_data2,
    input  logic        write_enable,
    input  logic [4:0]  write_reg,
    input  logic [31:0] write_data,
    output logic [31:0] register_v0
);

    logic [31:0] regs [0:31];

    assign read_data1 = regs[read_reg1];
    assign read_data2 = regs[read_reg2];

    // v0 is exposed for observing program results
    assign register_v0 = regs[2];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable && write_reg != 5'd0) begin
            // r0 is never written so it keeps its reset value of zero
            regs[write_reg] <= write_data;
        end
    end

endmodule

// ==== rtl/mips_cpu.sv ====
`timescale 1ns/1ps

module mips_cpu (
    input  logic        clk,
    input  logic        rst,
    output logic        active,
    output logic [31:0] register_v0,
    output logic [31:0] instr_address,
    input  logic [31:0] instr_readdata,
    output logic [31:0] data_address,
    output logic        data_write,
    output logic [3:0]  data_byteenable,
    output logic [31:0] data_writedata,
    input  logic [31:0] data_readdata
);

    import mips_pkg::*;

    logic [31:0] pc;
    logic [31:0] next_pc;
    logic [31:0] target_pc;
    logic        started;

    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [31:0] imm_ext;
    logic [25:0] jump_index;
    alu_op_t     alu_op;
    logic        use_imm;
    logic        reg_write;
    logic        write_rd;
    logic        mem_read;
    logic        mem_write;
    mem_size_t   mem_size;
    logic        load_unsigned;
    logic        is_beq;
    logic        is_bne;
    logic        is_j;
    logic        is_jr;

    logic [31:0] rs_data;
    logic [31:0] rt_data;
    logic [31:0] alu_b;
    logic [31:0] alu_result;
    logic        branch_taken;
    logic [1:0]  byte_off;
    logic [7:0]  load_byte;
    logic [15:0] load_half;
    logic [31:0] load_value;
    logic [31:0] write_data;

    mips_decoder u_decoder (
        .instr         (instr_readdata),
        .rs            (rs),
        .rt            (rt),
        .rd            (rd),
        .imm_ext       (imm_ext),
        .jump_index    (jump_index),
        .alu_op        (alu_op),
        .use_imm       (use_imm),
        .reg_write     (reg_write),
        .write_rd      (write_rd),
        .mem_read      (mem_read),
        .mem_write     (mem_write),
        .mem_size      (mem_size),
        .load_unsigned (load_unsigned),
        .is_beq        (is_beq),
        .is_bne        (is_bne),
        .is_j          (is_j),
        .is_jr         (is_jr)
    );

    mips_regfile u_regfile (
        .clk          (clk),
        .rst          (rst),
        .read_reg1    (rs),
        .read_reg2    (rt),
        .read_data1   (rs_data),
        .read_data2   (rt_data),
        .write_enable (active && reg_write),
        .write_reg    (write_rd ? rd : rt),
        .write_data   (write_data),
        .register_v0  (register_v0)
    );

    assign alu_b = use_imm ? imm_ext : rt_data;

    mips_alu u_alu (
        .op     (alu_op),
        .a      (rs_data),
        .b      (alu_b),
        .result (alu_result)
    );

    // fetching from address zero means the program has ended
    assign active = started && (pc != 32'd0);
    assign instr_address = pc;

    assign branch_taken = (is_beq && alu_result == 32'd0) || (is_bne && alu_result != 32'd0);

    // next_pc already points at the delay slot, so targets are based on it
    always_comb begin
        if (is_jr) begin
            target_pc = rs_data;
        end else if (is_j) begin
            target_pc = {next_pc[31:28], jump_index, 2'b00};
        end else if (branch_taken) begin
            target_pc = next_pc + {imm_ext[29:0], 2'b00};
        end else begin
            target_pc = next_pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= reset_vector;
            next_pc <= reset_vector + 32'd4;
            started <= 1'b0;
        end else begin
            started <= 1'b1;
            if (active) begin
                pc <= next_pc;
                next_pc <= target_pc;
            end
        end
    end

    assign data_address = alu_result;
    assign data_write = active && mem_write;
    assign byte_off = alu_result[1:0];

    // store lane steering, data is replicated so the enables pick the lane
    always_comb begin
        case (mem_size)
            size_byte: begin
                data_writedata = {4{rt_data[7:0]}};
                data_byteenable = 4'b0001 << byte_off;
            end
            size_half: begin
                data_writedata = {2{rt_data[15:0]}};
                data_byteenable = byte_off[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                data_writedata = rt_data;
                data_byteenable = 4'b1111;
            end
        endcase
    end

    // load extraction with sign or zero extension
    assign load_byte = data_readdata[8*byte_off +: 8];
    assign load_half = byte_off[1] ? data_readdata[31:16] : data_readdata[15:0];

    always_comb begin
        case (mem_size)
            size_byte: begin
                load_value = {{24{load_byte[7] && !load_unsigned}}, load_byte};
            end
            size_half: begin
                load_value = {{16{load_half[15] && !load_unsigned}}, load_half};
            end
            default: begin
                load_value = data_readdata;
            end
        endcase
    end

    assign write_data = mem_read ? load_value : alu_result;

endmodule

// ==== rtl/mips_iram.sv ====
`timescale 1ns/1ps

module mips_iram (
    input  logic        clk,
    input  logic [31:0] instr_address,
    output logic [31:0] instr_readdata,
    input  logic        prog_we,
    input  logic [11:0] prog_addr,
    input  logic [31:0] prog_data
);

    import mips_pkg::*;

    logic [31:0] instr_ram [0:iram_words-1];
    logic [31:0] offset;
    logic [$clog2(iram_words)-1:0] index;

    // word index relative to the reset vector, wraps inside the array
    assign offset = instr_address - reset_vector;
    assign index = offset[$clog2(iram_words)+1:2];

    assign instr_readdata = instr_ram[index];

    // program load port
    always_ff @(posedge clk) begin
        if (prog_we) begin
            instr_ram[prog_addr] <= prog_data;
        end
    end

endmodule

// ==== rtl/mips_dram.sv ====
`timescale 1ns/1ps

module mips_dram (
    input  logic        clk,
    input  logic [31:0] data_address,
    input  logic        data_write,
    input  logic [3:0]  data_byteenable,
    input  logic [31:0] data_writedata,
    output logic [31:0] data_readdata
);

    import mips_pkg::*;

    logic [31:0] data_ram [0:dram_words-1];
    logic [$clog2(dram_words)-1:0] index;

    // word select, byte offset bits are ignored
    assign index = data_address[$clog2(dram_words)+1:2];

    assign data_readdata = data_ram[index];

    // little-endian lanes: lane 0 holds the lowest byte address
    always_ff @(posedge clk) begin
        if (data_write) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (data_byteenable[lane]) begin
                    data_ram[index][8*lane +: 8] <= data_writedata[8*lane +: 8];
                end
            end
        end
    end

endmodule

// ==== rtl/mips_system.sv ====
`timescale 1ns/1ps

module mips_system (
    input  logic        clk,
    input  logic        rst,
    input  logic        prog_we,
    input  logic [11:0] prog_addr,
    input  logic [31:0] prog_data,
    output logic        active,
    output logic [31:0] register_v0
);

    logic [31:0] instr_address;
    logic [31:0] instr_readdata;
    logic [31:0] data_address;
    logic        data_write;
    logic [3:0]  data_byteenable;
    logic [31:0] data_writedata;
    logic [31:0] data_readdata;

    mips_cpu u_cpu (
        .clk             (clk),
        .rst             (rst),
        .active          (active),
        .register_v0     (register_v0),
        .instr_address   (instr_address),
        .instr_readdata  (instr_readdata),
        .data_address    (data_address),
        .data_write      (data_write),
        .data_byteenable (data_byteenable),
        .data_writedata  (data_writedata),
        .data_readdata   (data_readdata)
    );

    // program words come in through the load port while rst is held
    mips_iram u_iram (
        .clk            (clk),
        .instr_address  (instr_address),
        .instr_readdata (instr_readdata),
        .prog_we        (prog_we),
        .prog_addr      (prog_addr),
        .prog_data      (prog_data)
    );

    mips_dram u_dram (
        .clk             (clk),
        .data_address    (data_address),
        .data_write      (data_write),
        .data_byteenable (data_byteenable),
        .data_writedata  (data_writedata),
        .data_readdata   (data_readdata)
    );

endmodule

// ==== test/mips_system_tb.sv ====
`timescale 1ns/1ps

module mips_system_tb;

    import mips_pkg::*;

    localparam int clk_period = 8;
    localparam int test_total = 5;
    localparam int cycles_per_test = 200;

    logic        clk = 1'b0;
    logic        rst;
    logic        prog_we;
    logic [11:0] prog_addr;
    logic [31:0] prog_data;
    logic        active;
    logic [31:0] register_v0;

    logic [31:0] program_words [$];
    logic [31:0] rand_state = 32'h913e_d605;
    int          error_count = 0;
    int          check_count = 0;
    int          test_count = 0;

    mips_system UUT (
        .clk         (clk),
        .rst         (rst),
        .prog_we     (prog_we),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .active      (active),
        .register_v0 (register_v0)
    );

    always #(clk_period / 2) clk = ~clk;

    function logic [31:0] next_random();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    function logic [31:0] sext16(input logic [15:0] value);
        return {{16{value[15]}}, value};
    endfunction

    // instruction word formats
    function logic [31:0] r_type(input logic [4:0] rs, input logic [4:0] rt,
                                 input logic [4:0] rd, input logic [5:0] fn);
        return {op_special, rs, rt, rd, 5'd0, fn};
    endfunction

    function logic [31:0] i_type(input logic [5:0] op, input logic [4:0] rs,
                                 input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function logic [31:0] j_type(input logic [5:0] op, input logic [31:0] target);
        return {op, target[27:2]};
    endfunction

    // builds a full 32-bit value with addiu and 16 doublings, since there is no lui
    task put_constant(input logic [4:0] rt, input logic [31:0] value);
        logic [15:0] upper;
        upper = value[31:16] + {15'd0, value[15]};
        program_words.push_back(i_type(op_addiu, 5'd0, rt, upper));
        repeat (16) program_words.push_back(r_type(rt, rt, rt, fn_addu));
        program_words.push_back(i_type(op_addiu, rt, rt, value[15:0]));
    endtask

    task end_program(input logic [31:0] delay_slot);
        program_words.push_back(r_type(5'd0, 5'd0, 5'd0, fn_jr));
        program_words.push_back(delay_slot);
    endtask

    // holds rst while the program goes in through the load port
    task load_program();
        rst = 1'b1;
        for (int i = 0; i < program_words.size(); i++) begin
            prog_we = 1'b1;
            prog_addr = i[11:0];
            prog_data = program_words[i];
            @(negedge clk);
        end
        prog_we = 1'b0;
        repeat (16) @(negedge clk);
        rst = 1'b0;
    endtask

    task wait_for_halt(input string name);
        int cycles;
        cycles = 0;
        while (!active && cycles < cycles_per_test) begin
            @(negedge clk);
            cycles++;
        end
        while (active && cycles < cycles_per_test) begin
            @(negedge clk);
            cycles++;
        end
        assert (cycles < cycles_per_test) else begin
            $display("%s: the CPU did not halt within %0d cycles", name, cycles_per_test);
            error_count++;
        end
    endtask

    task check_value(input string name, input logic [31:0] expected,
                     input logic [31:0] actual);
        check_count++;
        assert (actual === expected) else begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    task finish_test(input string name, input int errors_before);
        test_count++;
        $display("%s finished, %0d errors", name, error_count - errors_before);
    endtask

    task test_arith();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        int          errors_before;
        errors_before = error_count;
        a = next_random();
        b = next_random();
        r = next_random();
        program_words = {};
        put_constant(5'd8, a);
        put_constant(5'd9, b);
        program_words.push_back(i_type(op_addiu, 5'd8, 5'd10, r[15:0]));
        program_words.push_back(r_type(5'd10, 5'd9, 5'd11, fn_subu));
        program_words.push_back(r_type(5'd11, 5'd8, 5'd2, fn_addu));
        // writes to r0 are dropped, so v0 + r0 leaves v0 alone
        program_words.push_back(r_type(5'd2, 5'd9, 5'd0, fn_addu));
        program_words.push_back(i_type(op_addiu, 5'd0, 5'd0, 16'h0005));
        program_words.push_back(r_type(5'd2, 5'd0, 5'd2, fn_addu));
        end_program(32'h0);
        load_program();
        wait_for_halt("arith");
        check_value("arith", a + sext16(r[15:0]) - b + a, register_v0);
        finish_test("arith", errors_before);
    endtask

    task test_memory();
        logic [31:0] w;
        logic [31:0] x;
        logic [31:0] word0;
        logic [31:0] word1;
        int          errors_before;
        errors_before = error_count;
        w = next_random();
        // top bits of both bytes set so lb and lbu differ
        x = next_random() | 32'h0000_8080;
        program_words = {};
        put_constant(5'd9, w);
        put_constant(5'd10, x);
        program_words.push_back(i_type(op_addiu, 5'd0, 5'd8, 16'h0040));
        program_words.push_back(i_type(op_sw, 5'd8, 5'd9, 16'd0));
        program_words.push_back(i_type(op_sw, 5'd8, 5'd9, 16'd4));
        program_words.push_back(i_type(op_sb, 5'd8, 5'd10, 16'd1));
        program_words.push_back(i_type(op_sh, 5'd8, 5'd10, 16'd2));
        program_words.push_back(i_type(op_sb, 5'd8, 5'd10, 16'd7));
        program_words.push_back(i_type(op_lw, 5'd8, 5'd11, 16'd0));
        program_words.push_back(i_type(op_lw, 5'd8, 5'd14, 16'd4));
        program_words.push_back(i_type(op_lb, 5'd8, 5'd12, 16'd3));
        program_words.push_back(i_type(op_lbu, 5'd8, 5'd13, 16'd1));
        program_words.push_back(r_type(5'd11, 5'd14, 5'd15, fn_addu));
        program_words.push_back(r_type(5'd15, 5'd12, 5'd15, fn_addu));
        program_words.push_back(r_type(5'd15, 5'd13, 5'd2, fn_subu));
        end_program(32'h0);
        load_program();
        wait_for_halt("memory");
        // little-endian lanes after the merges
        word0 = {x[15:8], x[7:0], x[7:0], w[7:0]};
        word1 = {x[7:0], w[23:0]};
        check_value("memory", word0 + word1 + {{24{x[15]}}, x[15:8]} - {24'd0, x[7:0]},
                    register_v0);
        finish_test("memory", errors_before);
    endtask

    task test_branch();
        logic [31:0] r;
        int          errors_before;
        errors_before = error_count;
        r = next_random();
        program_words = {};
        program_words.push_back(i_type(op_addiu, 5'd0, 5'd8, r[15:0]));
        program_words.push_back(i_type(op_addiu, 5'd0, 5'd9, r[15:0]));
        program_words.push_back(i_type(op_addiu, 5'd0, 5'd10, r[15:0] ^ 16'h0001));
        program_words.push_back(i_type(op_beq, 5'd8, 5'd9, 16'd2));
        program_words.push_back(i_type(op_addiu, 5'd2, 5'd2, 16'd1));
        program_words.push_back(i_type(op_addiu, 5'd2, 5'd2, 16'd100));
        program_words.push_back(i_type(op_bne, 5'd8, 5'd10, 16'd2));
        program_words.push_back(i_type(op_addiu, 5'd2, 5'd2, 16'd2));
        program_words.push_back(i_type(op_addiu, 5'd2, 5'd2, 16'd200));
        program_words.push_back(i_type(op_beq, 5'd8, 5'd10, 16'd5));
        program_words.push_back(i_type(op_addiu, 5'd2, 5'd2, 16'd4));
        program_words.push_back(i_type(op_addiu, 5'd2, 5'd2, 16'd8));
        program_words.push_back(i_type(op_bne, 5'd8, 5'd9, 16'd5));
        program_words.push_back(i_type(op_addiu, 5'd2, 5'd2, 16'd16));
        program_words.push_back(i_type(op_addiu, 5'd2, 5'd2, 16'd32));
        end_program(i_type(op_addiu, 5'd2, 5'd2, 16'd64));
        load_program();
        wait_for_halt("branch");
        // both delay slots and the not-taken paths run, the 100 and 200 words do not
        check_value("branch", 32'd1 + 32'd2 + 32'd4 + 32'd8 + 32'd16 + 32'd32 + 32'd64,
                    register_v0);
        finish_test("branch", errors_before);
    endtask

    task test_jump();
        int errors_before;
        errors_before = error_count;
        program_words = {};
        program_words.push_back(i_type(op_addiu, 5'd0, 5'd2, 16'd1));
        program_words.push_back(j_type(op_j, reset_vector + 32'd16));
        program_words.push_back(i_type(op_addiu, 5'd2, 5'd2, 16'd2));
        program_words.push_back(i_type(op_addiu, 5'd2, 5'd2, 16'd100));
        program_words.push_back(i_type(op_addiu, 5'd2, 5'd2, 16'd4));
        end_program(i_type(op_addiu, 5'd2, 5'd2, 16'd8));
        program_words.push_back(i_type(op_addiu, 5'd2, 5'd2, 16'd300));
        load_program();
        wait_for_halt("jump");
        check_value("jump", 32'd15, register_v0);
        repeat (20) begin
            @(negedge clk);
            assert (!active) else begin
                $display("jump: active went high again after the halt");
                error_count++;
            end
            check_value("jump hold", 32'd15, register_v0);
        end
        finish_test("jump", errors_before);
    endtask

    task test_reset();
        logic [31:0] expected;
        logic [31:0] r;
        int          errors_before;
        errors_before = error_count;
        expected = 32'd0;
        program_words = {};
        for (int i = 0; i < 12; i++) begin
            r = next_random();
            program_words.push_back(i_type(op_addiu, 5'd2, 5'd2, r[15:0]));
            expected = expected + sext16(r[15:0]);
        end
        end_program(32'h0);
        load_program();
        wait_for_halt("reset");
        check_value("reset first run", expected, register_v0);
        load_program();
        repeat (6) @(negedge clk);
        assert (active) else begin
            $display("reset: the CPU was not running before the mid-program reset");
            error_count++;
        end
        rst = 1'b1;
        @(negedge clk);
        assert (!active) else begin
            $display("reset: active stayed high while rst was asserted");
            error_count++;
        end
        check_value("reset clear", 32'd0, register_v0);
        repeat (15) @(negedge clk);
        rst = 1'b0;
        wait_for_halt("reset");
        check_value("reset rerun", expected, register_v0);
        finish_test("reset", errors_before);
    endtask

    initial begin
        rst = 1'b1;
        prog_we = 1'b0;
        prog_addr = 12'd0;
        prog_data = 32'd0;
        repeat (16) @(negedge clk);
        test_arith();
        test_memory();
        test_branch();
        test_jump();
        test_reset();
        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // bound on the whole run
    initial begin
        #(test_total * cycles_per_test * clk_period);
        $display("watchdog expired before all tests finished");
        $display("Test failed");
        $finish;
    end

endmodule

// ==== files.f ====
rtl/mips_pkg.sv
rtl/mips_alu.sv
rtl/mips_decoder.sv
rtl/mips_regfile.sv
rtl/mips_cpu.sv
rtl/mips_iram.sv
rtl/mips_dram.sv
rtl/mips_system.sv
test/mips_system_tb.sv
